// File: project.f
+incdir+.
drac_pkg.sv
icache_pkg.sv
icache_interface.sv
icache_ctrl.sv
icache_way.sv
icache_hit_merge.sv
icache_subsys.sv
tb_icache_subsys.sv

// File: Bender.yml
package:
  name: icache_subsys

export_include_dirs:
  - .

sources:
  - include_dirs:
      - .
    files:
      - drac_pkg.sv
      - icache_pkg.sv
      - icache_interface.sv
      - icache_ctrl.sv
      - icache_way.sv
      - icache_hit_merge.sv
      - icache_subsys.sv
  - target: test
    include_dirs:
      - .
    files:
      - tb_icache_subsys.sv

// File: tb_icache_subsys.sv
/* Testbench for the instruction cache. Memory answers after 1 to 4 random cycles.
   A reference model predicts hit or miss per set. The run stops at the first error */
`timescale 1ns/1ns
`default_nettype none
`include "icache_config.svh"

module tb_icache_subsys
    import drac_pkg::*;
    import icache_pkg::*;
;

    localparam int unsigned NUM_SETS   = 2**`ICACHE_SET_BITS;
    localparam int unsigned WAIT_LIMIT = 20;            // Cycles per wait loop
    localparam addr_t LINE_A = 40'h12_3456_7A50;        // A, B, C share set 0xA5
    localparam addr_t LINE_B = 40'h12_3457_8A50;
    localparam addr_t LINE_C = 40'h12_3458_9A50;
    localparam addr_t LINE_D = 40'h00_0000_1230;        // Set 0x23
    localparam addr_t LINE_E = 40'h00_000A_BCD4;        // Set 0xCD and word 1

    logic                  clk_i = 1'b0;
    logic                  rstn_i;
    req_cpu_icache_t       req_fetch;
    logic                  tlb_xcp;
    resp_icache_cpu_t      resp;
    logic                  fetch_ready;
    logic                  mem_req_valid;
    logic [`ADDR_SIZE-5:0] mem_req_line_addr;
    logic                  mem_resp_valid;
    icache_line_t          mem_resp_line;
    logic                  miss;
    int unsigned           err_count = 0;

    // Reference model state
    icache_vpn_t model_tag    [NUM_SETS][`ICACHE_WAYS];
    logic        model_valid  [NUM_SETS][`ICACHE_WAYS];
    int unsigned model_victim [NUM_SETS];

    icache_subsys UUT (
        .clk_i               (clk_i),
        .rstn_i              (rstn_i),
        .req_fetch_icache_i  (req_fetch),
        .tlb_resp_xcp_if_i   (tlb_xcp),
        .resp_icache_fetch_o (resp),
        .req_fetch_ready_o   (fetch_ready),
        .mem_req_valid_o     (mem_req_valid),
        .mem_req_line_addr_o (mem_req_line_addr),
        .mem_resp_valid_i    (mem_resp_valid),
        .mem_resp_line_i     (mem_resp_line),
        .miss_o              (miss)
    );

    always #50 clk_i = ~clk_i; // 100 ns period

    task automatic stop_run();
        err_count++;
        $display("Checks failed");
        $fatal(1, "Stopped at first error");
    endtask

    task automatic abort_run(input string msg);
        $display("%s", msg);
        stop_run();
    endtask

    task automatic report_mismatch(input string test, input string what,
                                   input logic [63:0] exp, input logic [63:0] act);
        $display("[FAIL] %s: %s expected %0h actual %0h", test, what, exp, act);
        stop_run();
    endtask

    task automatic check_eq(input string test, input string what,
                            input logic [63:0] exp, input logic [63:0] act);
        assert (exp === act) else report_mismatch(test, what, exp, act);
    endtask

    // Word k of line L by the memory content rule
    function automatic logic [31:0] mem_word(input logic [`ADDR_SIZE-5:0] line_addr,
                                             input int unsigned k);
        logic [`ADDR_SIZE-1:0] byte_addr;
        byte_addr = {line_addr, 4'h0} + `ADDR_SIZE'(4 * k);
        return byte_addr[31:0] ^ 32'h13579BDF;
    endfunction

    function automatic logic model_lookup(input addr_t va);
        logic hit;
        hit = 1'b0;
        for (int w = 0; w < `ICACHE_WAYS; w++) begin
            if (model_valid[va[`ICACHE_SET_BITS+3:4]][w] &&
                model_tag[va[`ICACHE_SET_BITS+3:4]][w] == va[`ADDR_SIZE-1:12]) begin
                hit = 1'b1;
            end
        end
        return hit;
    endfunction

    task automatic model_fill(input addr_t va);
        int unsigned set;
        set = va[`ICACHE_SET_BITS+3:4];
        model_tag[set][model_victim[set]]   = va[`ADDR_SIZE-1:12];
        model_valid[set][model_victim[set]] = 1'b1;
        model_victim[set] = (model_victim[set] + 1) % `ICACHE_WAYS; // Round robin
    endtask

    task automatic model_flush();
        for (int s = 0; s < NUM_SETS; s++) begin
            for (int w = 0; w < `ICACHE_WAYS; w++) begin
                model_valid[s][w] = 1'b0;
            end
        end
    endtask

    task automatic wait_ready(input string test);
        int unsigned waited;
        waited = 0;
        while (!fetch_ready) begin
            waited++;
            if (waited > WAIT_LIMIT) abort_run({test, ": fetch ready never returned"});
            @(posedge clk_i);
            #5;
        end
    endtask

    // One fetch with an optional cache invalidate or a kill in the next cycle
    task automatic do_fetch(input string test, input addr_t va, input logic inval,
                            input logic kill);
        logic        exp_hit;
        logic [31:0] exp_word;
        int unsigned waited;
        wait_ready(test);
        if (inval) model_flush();        // Flush lands before the lookup
        exp_hit  = model_lookup(va);
        exp_word = mem_word(va[`ADDR_SIZE-1:4], va[3:2]);
        req_fetch.valid             = 1'b1;
        req_fetch.vaddr             = va;
        req_fetch.invalidate_icache = inval;
        @(posedge clk_i);                // Accept edge
        #5;
        req_fetch             = '0;
        req_fetch.inval_fetch = kill;
        @(negedge clk_i);
        check_eq(test, "miss_o", !exp_hit, miss);
        check_eq(test, "mem_req_valid_o", !exp_hit, mem_req_valid);
        check_eq(test, "ready after accept", 0, fetch_ready);
        if (exp_hit) begin
            check_eq(test, "hit response valid", !kill, resp.valid);
            if (!kill) check_eq(test, "hit data", exp_word, resp.data);
        end else begin
            check_eq(test, "line address", va[`ADDR_SIZE-1:4], mem_req_line_addr);
            check_eq(test, "response during miss", 0, resp.valid);
            @(posedge clk_i);
            #5;
            req_fetch.inval_fetch = 1'b0;
            waited = 0;
            @(negedge clk_i);
            while (!mem_resp_valid) begin
                waited++;
                if (waited > WAIT_LIMIT) abort_run({test, ": memory response never came"});
                check_eq(test, "response before refill", 0, resp.valid);
                check_eq(test, "ready during refill", 0, fetch_ready);
                @(negedge clk_i);
            end
            check_eq(test, "refill response valid", !kill, resp.valid);
            if (!kill) check_eq(test, "refill data", exp_word, resp.data);
            model_fill(va);              // Killed refill still writes
        end
        @(posedge clk_i);
        #5;
        req_fetch.inval_fetch = 1'b0;
        check_eq(test, "ready after response", 1, fetch_ready);
    endtask

    task automatic fault_fetch(input string test, input addr_t va);
        wait_ready(test);
        tlb_xcp         = 1'b1;
        req_fetch.valid = 1'b1;
        req_fetch.vaddr = va;
        @(negedge clk_i);                // Same cycle answer
        check_eq(test, "fault response valid", 1, resp.valid);
        check_eq(test, "fault flag", 1, resp.instr_page_fault);
        check_eq(test, "fault data", 0, resp.data);
        check_eq(test, "memory request", 0, mem_req_valid);
        @(posedge clk_i);
        #5;
        req_fetch = '0;
        tlb_xcp   = 1'b0;
        @(negedge clk_i);
        check_eq(test, "memory request after fault", 0, mem_req_valid);
        check_eq(test, "ready after fault", 1, fetch_ready);
        @(posedge clk_i);
        #5;
    endtask

    // Memory model serving one line request at a time
    always begin : memory_model
        logic [`ADDR_SIZE-5:0] line_addr;
        int unsigned           lat;
        @(negedge clk_i);
        if (rstn_i && mem_req_valid) begin
            line_addr = mem_req_line_addr;
            lat       = ($urandom % 4) + 1;
            repeat (lat) @(posedge clk_i);
            #5;
            mem_resp_valid = 1'b1;
            for (int k = 0; k < 4; k++) begin
                mem_resp_line[32*k +: 32] = mem_word(line_addr, k);
            end
            @(posedge clk_i);
            #5;
            mem_resp_valid = 1'b0;
        end
    end

    assert property (@(posedge clk_i) disable iff (!rstn_i) miss == mem_req_valid)
        else report_mismatch("miss_pulse", "miss_o", mem_req_valid, miss);
    assert property (@(posedge clk_i) disable iff (!rstn_i) mem_req_valid |-> !fetch_ready)
        else abort_run("Memory request issued while fetch ready was high");
    // Refill request is a single-cycle pulse
    assert property (@(posedge clk_i) disable iff (!rstn_i) mem_req_valid |=> !mem_req_valid)
        else abort_run("Memory request held for more than one cycle");
    // Cache responses only come while busy
    assert property (@(posedge clk_i) disable iff (!rstn_i)
                     (resp.valid && !resp.instr_page_fault) |-> !fetch_ready)
        else abort_run("Cache response seen while fetch ready was high");

    initial begin : watchdog
        repeat (4000) @(posedge clk_i);
        abort_run("Simulation cycle limit reached");
    end

    initial begin
        void'($urandom(32'h96646881)); // Single seed for the run
        rstn_i         = 1'b0;
        req_fetch      = '0;
        tlb_xcp        = 1'b0;
        mem_resp_valid = 1'b0;
        mem_resp_line  = '0;
        for (int s = 0; s < NUM_SETS; s++) begin
            model_victim[s] = 0;
            for (int w = 0; w < `ICACHE_WAYS; w++) begin
                model_valid[s][w] = 1'b0;
                model_tag[s][w]   = '0;
            end
        end
        repeat (16) @(posedge clk_i);
        #5;
        rstn_i = 1'b1;
        @(negedge clk_i);
        check_eq("reset", "fetch ready", 1, fetch_ready);
        check_eq("reset", "mem_req_valid_o", 0, mem_req_valid);
        check_eq("reset", "miss_o", 0, miss);
        check_eq("reset", "response valid", 0, resp.valid);
        @(posedge clk_i);
        #5;
        do_fetch("cold_miss", LINE_A, 1'b0, 1'b0);
        do_fetch("hit_after_fill", LINE_A, 1'b0, 1'b0);
        for (int k = 0; k < 4; k++) begin
            do_fetch("word_select", LINE_A + addr_t'(4 * k), 1'b0, 1'b0);
        end
        do_fetch("fill_second_way", LINE_B, 1'b0, 1'b0);
        do_fetch("both_hit_a", LINE_A, 1'b0, 1'b0);
        do_fetch("both_hit_b", LINE_B, 1'b0, 1'b0);
        do_fetch("evict_by_c", LINE_C, 1'b0, 1'b0);
        do_fetch("b_survives", LINE_B, 1'b0, 1'b0);
        do_fetch("a_evicted", LINE_A, 1'b0, 1'b0);
        do_fetch("inval_setup", LINE_D, 1'b0, 1'b0);
        do_fetch("inval_setup_hit", LINE_D, 1'b0, 1'b0);
        do_fetch("invalidate", LINE_D, 1'b1, 1'b0);  // Hit before and now refills
        do_fetch("hit_after_inval", LINE_D, 1'b0, 1'b0);
        do_fetch("flush_all_sets", LINE_A, 1'b0, 1'b0); // Other sets lost their lines too
        fault_fetch("page_fault", LINE_D + 40'h4);
        do_fetch("kill_miss", LINE_E, 1'b0, 1'b1);
        do_fetch("hit_after_kill", LINE_E, 1'b0, 1'b0);
        if (err_count == 0) begin
            $display("All checks passed");
            $finish;
        end else begin
            stop_run();
        end
    end

endmodule

`default_nettype wire

// File: icache_subsys.sv
/* Instruction cache top, virtually tagged, no TLB. Memory port is single beat:
   one request pulse, then one response strobe with the full line */
`timescale 1ns/1ns
`default_nettype none
`include "icache_config.svh"

module icache_subsys
    import drac_pkg::*;
    import icache_pkg::*;
(
    input  wire logic               clk_i,
    input  wire logic               rstn_i,
    input  wire req_cpu_icache_t    req_fetch_icache_i,
    input  wire logic               tlb_resp_xcp_if_i,
    output resp_icache_cpu_t        resp_icache_fetch_o,
    output logic                    req_fetch_ready_o,
    output logic                    mem_req_valid_o,
    output logic [`ADDR_SIZE-5:0]   mem_req_line_addr_o, // vaddr bits 39:4
    input  wire logic               mem_resp_valid_i,
    input  wire icache_line_t       mem_resp_line_i,
    output logic                    miss_o
);

    logic                                icache_req_valid;
    logic                                icache_req_ready;
    icache_idx_t                         icache_req_bits_idx;
    icache_vpn_t                         icache_req_bits_vpn;
    logic                                icache_req_kill;
    logic                                icache_invalidate;
    logic                                icache_resp_valid;
    icache_line_t                        icache_resp_datablock;
    icache_way_req_t                     way_req;
    logic [`ICACHE_WAYS-1:0]             way_wr;
    icache_way_resp_t [`ICACHE_WAYS-1:0] way_resp;
    icache_line_t                        refill_line;
    logic                                refill_done;
    logic                                resp_en;
    logic                                hit;

    icache_interface u_interface (
        .clk_i                   (clk_i),
        .rstn_i                  (rstn_i),
        .req_fetch_icache_i      (req_fetch_icache_i),
        .tlb_resp_xcp_if_i       (tlb_resp_xcp_if_i),
        .icache_resp_datablock_i (icache_resp_datablock),
        .icache_resp_valid_i     (icache_resp_valid),
        .icache_req_ready_i      (icache_req_ready),
        .icache_invalidate_o     (icache_invalidate),
        .icache_req_bits_idx_o   (icache_req_bits_idx),
        .icache_req_kill_o       (icache_req_kill),
        .icache_req_valid_o      (icache_req_valid),
        .icache_req_bits_vpn_o   (icache_req_bits_vpn),
        .resp_icache_fetch_o     (resp_icache_fetch_o),
        .req_fetch_ready_o       (req_fetch_ready_o)
    );

    icache_ctrl u_ctrl (
        .clk_i               (clk_i),
        .rstn_i              (rstn_i),
        .req_valid_i         (icache_req_valid),
        .req_idx_i           (icache_req_bits_idx),
        .req_vpn_i           (icache_req_bits_vpn),
        .kill_i              (icache_req_kill),
        .invalidate_i        (icache_invalidate),
        .hit_i               (hit),
        .req_ready_o         (icache_req_ready),
        .way_req_o           (way_req),
        .way_wr_o            (way_wr),
        .refill_line_o       (refill_line),
        .refill_done_o       (refill_done),
        .resp_en_o           (resp_en),
        .mem_req_valid_o     (mem_req_valid_o),
        .mem_req_line_addr_o (mem_req_line_addr_o),
        .mem_resp_valid_i    (mem_resp_valid_i),
        .mem_resp_line_i     (mem_resp_line_i),
        .miss_o              (miss_o)
    );

    // Same request to every way, one-hot write select
    for (genvar g = 0; g < `ICACHE_WAYS; g++) begin : g_way
        icache_way u_way (
            .clk_i      (clk_i),
            .rstn_i     (rstn_i),
            .way_req_i  (way_req),
            .wr_en_i    (way_wr[g]),
            .way_resp_o (way_resp[g])
        );
    end

    icache_hit_merge u_merge (
        .way_resp_i    (way_resp),
        .refill_line_i (refill_line),
        .refill_done_i (refill_done),
        .resp_en_i     (resp_en),
        .hit_o         (hit),
        .resp_valid_o  (icache_resp_valid),
        .resp_line_o   (icache_resp_datablock)
    );

endmodule

`default_nettype wire

// File: icache_hit_merge.sv
/* Combines way results into one response. Hits are assumed one-hot;
   a completing refill takes priority over the hit line */
`timescale 1ns/1ns
`default_nettype none
`include "icache_config.svh"

module icache_hit_merge
    import icache_pkg::*;
(
    input  wire icache_way_resp_t [`ICACHE_WAYS-1:0] way_resp_i,
    input  wire icache_line_t                        refill_line_i,
    input  wire logic                                refill_done_i,
    input  wire logic                                resp_en_i,     // Cleared on kill
    output logic                                     hit_o,
    output logic                                     resp_valid_o,
    output icache_line_t                             resp_line_o
);

    icache_line_t hit_line;

    always_comb begin
        hit_o    = 1'b0;
        hit_line = '0;
        for (int w = 0; w < `ICACHE_WAYS; w++) begin
            hit_o    = hit_o | way_resp_i[w].hit;
            // Non-hitting ways masked to zero
            hit_line = hit_line | (way_resp_i[w].line & {`ICACHE_LINE_BITS{way_resp_i[w].hit}});
        end
    end

    assign resp_line_o  = refill_done_i ? refill_line_i : hit_line;
    assign resp_valid_o = resp_en_i & (refill_done_i | hit_o);

endmodule

`default_nettype wire

// File: icache_way.sv
/* One cache way. Read data and hit appear the cycle after rd_en and hold
   until the next read. A write in the same cycle as a flush stays valid */
`timescale 1ns/1ns
`default_nettype none
`include "icache_config.svh"

module icache_way
    import icache_pkg::*;
(
    input  wire logic             clk_i,
    input  wire logic             rstn_i,
    input  wire icache_way_req_t  way_req_i,
    input  wire logic             wr_en_i,    // Refill this way
    output icache_way_resp_t      way_resp_o
);

    localparam int unsigned NUM_SETS = 2**`ICACHE_SET_BITS;

    icache_vpn_t          tag_mem  [NUM_SETS];
    icache_line_t         data_mem [NUM_SETS];
    logic [NUM_SETS-1:0]  valid_q;
    logic                 rd_valid_q;  // Valid bit as read
    icache_vpn_t          rd_tag_q;    // Stored tag as read
    icache_vpn_t          req_tag_q;   // Requested tag for the compare
    icache_line_t         rd_line_q;

    always_ff @(posedge clk_i, negedge rstn_i) begin
        if (!rstn_i) begin
            valid_q    <= '0;
            rd_valid_q <= 1'b0;
        end else begin
            if (way_req_i.flush) begin
                valid_q <= '0;
            end
            if (wr_en_i) begin
                valid_q[way_req_i.set] <= 1'b1;
            end
            if (way_req_i.rd_en) begin
                rd_valid_q <= valid_q[way_req_i.set] & ~way_req_i.flush; // Flush wins
            end
        end
    end

    // Arrays and read registers
    always_ff @(posedge clk_i) begin
        if (wr_en_i) begin
            tag_mem[way_req_i.set]  <= way_req_i.tag;
            data_mem[way_req_i.set] <= way_req_i.wr_line;
        end
        if (way_req_i.rd_en) begin
            rd_tag_q  <= tag_mem[way_req_i.set];
            rd_line_q <= data_mem[way_req_i.set];
            req_tag_q <= way_req_i.tag;
        end
    end

    assign way_resp_o.hit  = rd_valid_q & (rd_tag_q == req_tag_q);
    assign way_resp_o.line = rd_line_q;

endmodule

`default_nettype wire

// File: icache_ctrl.sv
/* Lookup and refill FSM handling one request at a time. Kill drops the response
   only and the refill still fills the victim way. Victim pointers are round robin per set */
`timescale 1ns/1ns
`default_nettype none
`include "icache_config.svh"

module icache_ctrl
    import icache_pkg::*;
(
    input  wire logic                clk_i,
    input  wire logic                rstn_i,
    input  wire logic                req_valid_i,
    input  wire icache_idx_t         req_idx_i,
    input  wire icache_vpn_t         req_vpn_i,
    input  wire logic                kill_i,
    input  wire logic                invalidate_i,
    input  wire logic                hit_i,           // From the merge and valid in LOOKUP
    output logic                     req_ready_o,
    output icache_way_req_t          way_req_o,
    output logic [`ICACHE_WAYS-1:0]  way_wr_o,        // One-hot fill strobe
    output icache_line_t             refill_line_o,
    output logic                     refill_done_o,
    output logic                     resp_en_o,
    output logic                     mem_req_valid_o,
    output logic [`ADDR_SIZE-5:0]    mem_req_line_addr_o,
    input  wire logic                mem_resp_valid_i,
    input  wire icache_line_t        mem_resp_line_i,
    output logic                     miss_o
);

    localparam int unsigned NUM_SETS = 2**`ICACHE_SET_BITS;
    localparam int unsigned PTR_BITS = (`ICACHE_WAYS > 1) ? $clog2(`ICACHE_WAYS) : 1;

    icache_state_t       state_q, state_d;
    icache_set_t         set_q;              // Set of the request in flight
    icache_vpn_t         tag_q;
    logic                drop_q;             // Response suppressed by a kill
    logic [PTR_BITS-1:0] victim_q [NUM_SETS];
    icache_set_t         req_set;
    logic                accept;
    logic                fill;
    logic                drop;

    assign req_set     = req_idx_i[`ICACHE_SET_BITS+3:4];
    assign req_ready_o = (state_q == IDLE);
    assign accept      = req_valid_i & req_ready_o;
    assign fill        = (state_q == REFILL_WAIT) & mem_resp_valid_i; // Line arrives
    assign drop        = drop_q | (kill_i & ~req_ready_o);

    always_comb begin
        state_d = state_q;
        case (state_q)
            IDLE: begin
                if (accept) begin
                    // A flush in the read cycle makes the lookup a sure miss
                    state_d = invalidate_i ? REFILL_REQ : LOOKUP;
                end
            end
            LOOKUP:      state_d = hit_i ? IDLE : REFILL_WAIT;
            REFILL_REQ:  state_d = REFILL_WAIT;
            REFILL_WAIT: state_d = mem_resp_valid_i ? IDLE : REFILL_WAIT;
            default:     state_d = IDLE;
        endcase
    end

    always_ff @(posedge clk_i, negedge rstn_i) begin
        if (!rstn_i) begin
            state_q <= IDLE;
            drop_q  <= 1'b0;
        end else begin
            state_q <= state_d;
            if (state_d == IDLE) begin
                drop_q <= 1'b0;
            end else if (kill_i && !req_ready_o) begin
                drop_q <= 1'b1;
            end
        end
    end

    // Request address capture
    always_ff @(posedge clk_i) begin
        if (accept) begin
            set_q <= req_set;
            tag_q <= req_vpn_i;
        end
    end

    always_ff @(posedge clk_i, negedge rstn_i) begin
        if (!rstn_i) begin
            for (int s = 0; s < NUM_SETS; s++) begin
                victim_q[s] <= '0;
            end
        end else if (fill) begin
            victim_q[set_q] <= victim_q[set_q] + 1'b1; // Wraps at way count
        end
    end

    always_comb begin
        way_req_o.rd_en   = accept;
        way_req_o.set     = req_ready_o ? req_set : set_q;
        way_req_o.tag     = req_ready_o ? req_vpn_i : tag_q;
        way_req_o.flush   = invalidate_i;
        way_req_o.wr_line = mem_resp_line_i;
        for (int w = 0; w < `ICACHE_WAYS; w++) begin
            way_wr_o[w] = fill && (victim_q[set_q] == PTR_BITS'(w));
        end
    end

    assign mem_req_valid_o     = (state_q == REFILL_REQ) | ((state_q == LOOKUP) & ~hit_i);
    assign mem_req_line_addr_o = {tag_q, set_q};
    assign miss_o              = mem_req_valid_o; // One pulse per refill
    assign refill_line_o       = mem_resp_line_i;
    assign refill_done_o       = fill;
    assign resp_en_o           = ((state_q == LOOKUP) | fill) & ~drop;

endmodule

`default_nettype wire

// File: icache_interface.sv
/* Fetch-side adapter. Page faults answer in the request cycle without a cache access.
   Word select uses the PC held from the last accepted request */
`timescale 1ns/1ns
`default_nettype none
`include "icache_config.svh"

module icache_interface
    import drac_pkg::*;
    import icache_pkg::*;
(
    input  wire logic             clk_i,
    input  wire logic             rstn_i,
    input  wire req_cpu_icache_t  req_fetch_icache_i,
    input  wire logic             tlb_resp_xcp_if_i,      // Instruction page fault level
    input  wire icache_line_t     icache_resp_datablock_i,
    input  wire logic             icache_resp_valid_i,
    input  wire logic             icache_req_ready_i,
    output logic                  icache_invalidate_o,
    output icache_idx_t           icache_req_bits_idx_o,
    output logic                  icache_req_kill_o,
    output logic                  icache_req_valid_o,
    output icache_vpn_t           icache_req_bits_vpn_o,
    output resp_icache_cpu_t      resp_icache_fetch_o,
    output logic                  req_fetch_ready_o
);

    logic      do_request; // Request accepted this cycle, fault or not
    logic      pf_resp;    // Immediate fault response
    reg_addr_t old_pc_q;   // PC of the request being answered

    assign do_request = req_fetch_icache_i.valid & ~req_fetch_icache_i.invalidate_buffer &
                        icache_req_ready_i;
    assign pf_resp    = do_request & tlb_resp_xcp_if_i;

    // Address split toward the cache
    assign icache_req_bits_vpn_o = req_fetch_icache_i.vaddr[`ADDR_SIZE-1:12];
    assign icache_req_bits_idx_o = req_fetch_icache_i.vaddr[11:0];
    assign icache_req_valid_o    = do_request & ~tlb_resp_xcp_if_i; // No access on fault
    assign icache_req_kill_o     = req_fetch_icache_i.inval_fetch;
    assign icache_invalidate_o   = req_fetch_icache_i.invalidate_icache;
    assign req_fetch_ready_o     = icache_req_ready_i;

    // Hold the PC until the next accepted request
    always_ff @(posedge clk_i, negedge rstn_i) begin
        if (!rstn_i) begin
            old_pc_q <= '0;
        end else if (do_request) begin
            old_pc_q <= req_fetch_icache_i.vaddr;
        end
    end

    always_comb begin
        resp_icache_fetch_o.valid            = pf_resp | icache_resp_valid_i;
        resp_icache_fetch_o.instr_page_fault = pf_resp;
        if (pf_resp) begin
            resp_icache_fetch_o.data = 32'h0; // Faulting fetch returns no data
        end else begin
            case (old_pc_q[3:2])
                2'b00:   resp_icache_fetch_o.data = icache_resp_datablock_i[31:0];
                2'b01:   resp_icache_fetch_o.data = icache_resp_datablock_i[63:32];
                2'b10:   resp_icache_fetch_o.data = icache_resp_datablock_i[95:64];
                default: resp_icache_fetch_o.data = icache_resp_datablock_i[127:96];
            endcase
        end
    end

endmodule

`default_nettype wire

// File: icache_pkg.sv
/* Cache-internal types: line, index split, way request and response, FSM states.
   Widths follow the config macros */
`default_nettype none
`include "icache_config.svh"

package icache_pkg;

    typedef logic [`ICACHE_LINE_BITS-1:0] icache_line_t;   // 16-byte line
    typedef logic [11:0]                  icache_idx_t;    // Page offset
    typedef logic [`ADDR_SIZE-13:0]       icache_vpn_t;    // VPN, used as tag
    typedef logic [`ICACHE_SET_BITS-1:0]  icache_set_t;    // Set index

    // Broadcast to every way
    typedef struct packed {
        logic         rd_en;   // Start a tag and data read
        icache_set_t  set;
        icache_vpn_t  tag;     // Compare tag on read, store tag on write
        logic         flush;   // Clear all valid bits
        icache_line_t wr_line; // Refill data
    } icache_way_req_t;

    // Per-way read result
    typedef struct packed {
        logic         hit;
        icache_line_t line;
    } icache_way_resp_t;

    // Controller states
    typedef enum logic [1:0] {
        IDLE,        // Ready for a request
        LOOKUP,      // Tag compare result available
        REFILL_REQ,  // Known miss after a flush, issue refill
        REFILL_WAIT  // Waiting for the memory line
    } icache_state_t;

endpackage

`default_nettype wire

// File: drac_pkg.sv
/* Core-facing types shared by fetch and the instruction cache.
   Address width comes from the cache config macros */
`default_nettype none
`include "icache_config.svh"

package drac_pkg;

    typedef logic [`ADDR_SIZE-1:0] addr_t;     // Fetch virtual address
    typedef logic [`ADDR_SIZE-1:0] reg_addr_t; // Registered PC

    // Fetch request packet, 44 bits
    typedef struct packed {
        logic  valid;
        addr_t vaddr;
        logic  invalidate_icache; // Flush all lines
        logic  invalidate_buffer; // Blocks the cache request
        logic  inval_fetch;       // Kill the request in flight
    } req_cpu_icache_t;

    // Response packet back to fetch, 34 bits
    typedef struct packed {
        logic        valid;
        logic [31:0] data;            // One instruction word
        logic        instr_page_fault;
    } resp_icache_cpu_t;

endpackage

`default_nettype wire

// File: icache_config.svh
/* Cache geometry and address width. Set and line bits must agree with a
   16-byte line indexed by vaddr bits 11:4. Ways must be a power of two */
`ifndef ICACHE_CONFIG_SVH
`define ICACHE_CONFIG_SVH

// Virtual address width of the fetch path
`define ADDR_SIZE 40

// Associativity, 2 by default and 4 also supported
`define ICACHE_WAYS 2

// Set index width, 256 sets
`define ICACHE_SET_BITS 8

// One cache line, four 32-bit words
`define ICACHE_LINE_BITS 128

`endif
